/* common/wbuf_pkg.sv */
// shared types of the write buffer, imported by the rtl modules and the testbench

`include "wbuf_settings.svh"

package wbuf_pkg;

  ////////////////////
  // plain widths
  ////////////////////

  typedef logic [`WBUF_XLEN-1:0]            data_t;
  typedef logic [`WBUF_NBYTES-1:0]          be_t;
  typedef logic [`WBUF_WADDR_W-1:0]         waddr_t;
  typedef logic [`WBUF_OFF_W-1:0]           boff_t;
  // log2 of the bytes moved: byte, half, word, dword
  typedef logic [1:0]                       size_t;
  typedef logic [$clog2(`WBUF_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0]  tx_id_t;

  ////////////////////
  // bundles
  ////////////////////

  // core store, be selects the bytes written
  typedef struct packed {
    waddr_t waddr;
    data_t  data;
    be_t    be;
  } wr_req_t;

  // write towards memory, off and size give the aligned byte range
  typedef struct packed {
    waddr_t waddr;
    boff_t  off;
    size_t  size;
    data_t  data;
    tx_id_t id;
  } mem_req_t;

  // one buffer word, every byte has valid, dirty and in-flight bits
  typedef struct packed {
    waddr_t waddr;
    data_t  data;
    be_t    valid;
    be_t    dirty;
    be_t    txblock;
  } entry_t;

  // one transaction slot, remembers which bytes of which entry went out
  typedef struct packed {
    logic vld;
    be_t  be;
    ptr_t ptr;
  } tx_stat_t;

endpackage

/* common/wbuf_settings.svh */
// buffer sizing and width constants, included by the package and by every wbuf module

`ifndef WBUF_SETTINGS_SVH
`define WBUF_SETTINGS_SVH

////////////////////
// buffer sizing
////////////////////

// number of word entries in the coalescing buffer
`define WBUF_DEPTH 8

// number of transaction ids that can be in flight at once
`define WBUF_MAX_TX 4

////////////////////
// widths
////////////////////

// data word width in bits
`define WBUF_XLEN 64
// bytes per word, one mask bit each
`define WBUF_NBYTES (`WBUF_XLEN / 8)
// byte offset inside a word
`define WBUF_OFF_W 3
// word address, a 32 bit byte address without the offset bits
`define WBUF_WADDR_W 29

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the write buffer testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
  --top-module wbuf_tb -Mdir "$BUILD_DIR" -o wbuf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/wbuf_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0

/* sim.f */
+incdir+common
+incdir+verif
common/wbuf_pkg.sv
wbuf/wbuf_store.sv
wbuf/wbuf_tx_select.sv
wbuf/wbuf_tx_tracker.sv
wbuf/wbuf_top.sv
verif/wbuf_tb.sv

/* verif/wbuf_model.svh */
// reference model of the write buffer, included inside the testbench module

`ifndef WBUF_MODEL_SVH
`define WBUF_MODEL_SVH

// few words only, so stores coalesce and the buffer fills up
localparam int NWORDS = 12;

waddr_t word_addr [NWORDS];
// image left by accepted stores, and the image memory received
data_t  exp_img [NWORDS];
data_t  mem_img [NWORDS];
be_t    written [NWORDS];
be_t    mem_be [NWORDS];
// bytes stored but not yet sent
be_t    pend_be [NWORDS];
// at most one transfer per word in flight
logic   in_flight [NWORDS];
// outstanding ids, their word, earliest cycle of their return
logic   tx_out [`WBUF_MAX_TX];
int     tx_word [`WBUF_MAX_TX];
int     tx_ready [`WBUF_MAX_TX];

task automatic model_reset();
  for (int w = 0; w < NWORDS; w++) begin
    // spread apart in the address space
    word_addr[w] = waddr_t'(32'h0000_1000 + w * 37);
    exp_img[w]   = '0;
    mem_img[w]   = '0;
    written[w]   = '0;
    mem_be[w]    = '0;
    pend_be[w]   = '0;
    in_flight[w] = 1'b0;
  end
  for (int i = 0; i < `WBUF_MAX_TX; i++) begin
    tx_out[i]   = 1'b0;
    tx_word[i]  = 0;
    tx_ready[i] = 0;
  end
endtask

// -1 when no stimulus word has this address
function automatic int word_index(input waddr_t a);
  int idx;
  idx = -1;
  for (int w = 0; w < NWORDS; w++) begin
    if (word_addr[w] == a) begin
      idx = w;
    end
  end
  return idx;
endfunction

function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
  data_t r;
  r = old_w;
  for (int b = 0; b < `WBUF_NBYTES; b++) begin
    if (be[b]) begin
      r[b*8 +: 8] = new_w[b*8 +: 8];
    end
  end
  return r;
endfunction

// byte mask widened to a bit mask
function automatic data_t byte_bits(input be_t be);
  data_t r;
  for (int b = 0; b < `WBUF_NBYTES; b++) begin
    r[b*8 +: 8] = {8{be[b]}};
  end
  return r;
endfunction

// bytes covered by a transfer of 2**size bytes at off
function automatic be_t size_mask(input boff_t off, input size_t size);
  be_t m;
  m = '0;
  for (int b = 0; b < `WBUF_NBYTES; b++) begin
    if ((b >= int'(off)) && (b < int'(off) + (1 << int'(size)))) begin
      m[b] = 1'b1;
    end
  end
  return m;
endfunction

// word still sits in the buffer for sure
function automatic logic word_held(input int w);
  return (pend_be[w] != '0) || in_flight[w];
endfunction

function automatic int out_count();
  int cnt;
  cnt = 0;
  for (int i = 0; i < `WBUF_MAX_TX; i++) begin
    if (tx_out[i]) begin
      cnt++;
    end
  end
  return cnt;
endfunction

`endif

/* verif/wbuf_tb.sv */
// testbench of the write buffer, random stores against an out-of-order memory responder

`timescale 1ns/100ps

`include "wbuf_settings.svh"

module wbuf_tb
  import wbuf_pkg::*;
();

  localparam int TRAFFIC_CYC = 3000;
  localparam int DRAIN_MAX   = 400;
  // cycles a store may wait for its grant
  localparam int GNT_WAIT    = 100;
  localparam int TEST_CYC    = 2 + TRAFFIC_CYC + DRAIN_MAX;

  logic     clk_i;
  logic     rst_ni;
  logic     wr_valid_i;
  wr_req_t  wr_req_i;
  logic     wr_gnt_o;
  logic     mem_req_o;
  mem_req_t mem_req_i_o;
  logic     mem_ack_i;
  logic     mem_rtrn_vld_i;
  tx_id_t   mem_rtrn_id_i;
  logic     empty_o;

  // stimulus, decided at the falling edge, driven after the next rising one
  logic   st_vld;
  int     st_word;
  data_t  st_data;
  be_t    st_be;
  int     st_wait;
  logic   ack_nxt;
  logic   rtrn_nxt;
  tx_id_t rtrn_id_nxt;

  // outputs sampled at the falling edge
  logic s_empty;
  logic s_req;

  int    cyc;
  string cur_test;
  int    test_checks;
  int    test_errs;
  int    total_checks;
  int    total_errs;
  int    n_tests;

  `include "wbuf_model.svh"

  wbuf_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_valid_i     (wr_valid_i),
    .wr_req_i       (wr_req_i),
    .wr_gnt_o       (wr_gnt_o),
    .mem_req_o      (mem_req_o),
    .mem_req_i_o    (mem_req_i_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i),
    .empty_o        (empty_o)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    test_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("Mismatch %s %s expected %h actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    test_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("Mismatch %s %s expected %b actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    test_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("Mismatch %s %s expected %b actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    test_errs++;
    $display("Error %s: %s", cur_test, msg);
  endtask

  task automatic finish_test();
    $display("test %-14s %0d checks, %0d errors", cur_test, test_checks, test_errs);
    total_checks += test_checks;
    total_errs   += test_errs;
    n_tests++;
    test_checks = 0;
    test_errs   = 0;
  endtask

  ////////////////////
  // model tracking
  ////////////////////

  task automatic track_send();
    int  w;
    be_t span;
    w = word_index(mem_req_i_o.waddr);
    if (w < 0) begin
      report_error($sformatf("transfer to address %h that no store used", mem_req_i_o.waddr));
    end else begin
      span = size_mask(mem_req_i_o.off, mem_req_i_o.size);
      // naturally aligned to its own size
      check_bit("shape_align", 1'b1,
                (int'(mem_req_i_o.off) % (1 << int'(mem_req_i_o.size))) == 0);
      check_bit("id_free", 1'b0, tx_out[mem_req_i_o.id]);
      check_bit("tx_limit", 1'b1, out_count() < `WBUF_MAX_TX);
      check_bit("word_overlap", 1'b0, in_flight[w]);
      // only bytes still waiting may go out
      check_be("send_dirty", span, span & pend_be[w]);
      mem_img[w] = merge_bytes(mem_img[w], mem_req_i_o.data, span);
      mem_be[w]  |= span;
      pend_be[w] &= ~span;
      in_flight[w] = 1'b1;
      tx_out[mem_req_i_o.id]   = 1'b1;
      tx_word[mem_req_i_o.id]  = w;
      tx_ready[mem_req_i_o.id] = cyc + 1 + int'($urandom_range(8, 0));
    end
  endtask

  task automatic track_return();
    int w;
    w = tx_word[mem_rtrn_id_i];
    in_flight[w] = 1'b0;
    tx_out[mem_rtrn_id_i] = 1'b0;
  endtask

  task automatic track_store(input logic held);
    // a word still in the buffer hits, so no wait
    if (held) begin
      check_bit("hit_grant", 1'b1, wr_gnt_o);
    end
    if (wr_gnt_o) begin
      exp_img[st_word] = merge_bytes(exp_img[st_word], st_data, st_be);
      written[st_word] |= st_be;
      pend_be[st_word] |= st_be;
      st_vld = 1'b0;
    end else begin
      st_wait++;
      if (st_wait > GNT_WAIT) begin
        report_error($sformatf("store to word %0d not granted within %0d cycles",
                               st_word, GNT_WAIT));
        st_vld = 1'b0;
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic plan_next(input logic traffic);
    int ready [$];
    int pick;
    if (traffic && !st_vld && ($urandom_range(9, 0) < 7)) begin
      st_vld  = 1'b1;
      st_word = int'($urandom_range(NWORDS - 1, 0));
      st_data = {$urandom, $urandom};
      st_be   = be_t'($urandom);
      st_wait = 0;
      if (st_be == '0) begin
        st_be = 8'h01;
      end
    end
    // random back-pressure while traffic runs
    ack_nxt  = traffic ? ($urandom_range(9, 0) < 6) : 1'b1;
    rtrn_nxt = 1'b0;
    for (int i = 0; i < `WBUF_MAX_TX; i++) begin
      if (tx_out[i] && (tx_ready[i] <= cyc)) begin
        ready.push_back(i);
      end
    end
    // any ready id may come back, so returns arrive out of order
    if ((ready.size() > 0) && (!traffic || ($urandom_range(1, 0) == 1))) begin
      pick        = int'($urandom_range(ready.size() - 1, 0));
      rtrn_nxt    = 1'b1;
      rtrn_id_nxt = tx_id_t'(ready[pick]);
    end
  endtask

  task automatic run_cycle(input logic traffic);
    logic held;
    @(posedge clk_i);
    #10;
    wr_valid_i     = st_vld;
    wr_req_i       = '{waddr: word_addr[st_word], data: st_data, be: st_be};
    mem_ack_i      = ack_nxt;
    mem_rtrn_vld_i = rtrn_nxt;
    mem_rtrn_id_i  = rtrn_id_nxt;
    @(negedge clk_i);
    cyc++;
    s_empty = empty_o;
    s_req   = mem_req_o;
    held    = st_vld && word_held(st_word);
    // send before store, a store in the same cycle stays dirty
    if (mem_req_o && mem_ack_i) begin
      track_send();
    end
    if (mem_rtrn_vld_i) begin
      track_return();
    end
    if (st_vld) begin
      track_store(held);
    end
    plan_next(traffic);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : p_main
    int   n;
    logic drained;
    void'($urandom(38746));
    rst_ni         = 1'b0;
    wr_valid_i     = 1'b0;
    wr_req_i       = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_id_i  = '0;
    model_reset();
    st_vld       = 1'b0;
    st_word      = 0;
    st_data      = '0;
    st_be        = '0;
    st_wait      = 0;
    ack_nxt      = 1'b0;
    rtrn_nxt     = 1'b0;
    rtrn_id_nxt  = '0;
    cyc          = 0;
    test_checks  = 0;
    test_errs    = 0;
    total_checks = 0;
    total_errs   = 0;
    n_tests      = 0;

    cur_test = "reset_state";
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("gnt_after_reset", 1'b1, wr_gnt_o);
    check_bit("req_after_reset", 1'b0, mem_req_o);
    check_bit("empty_after_reset", 1'b1, empty_o);
    finish_test();

    cur_test = "random_traffic";
    repeat (TRAFFIC_CYC) run_cycle(1'b1);
    finish_test();

    // no new stores, memory acks at once and returns as soon as ready
    cur_test = "drain";
    drained  = 1'b0;
    n        = 0;
    while (!drained && (n < DRAIN_MAX)) begin
      run_cycle(1'b0);
      n++;
      drained = s_empty && !s_req && (out_count() == 0) && !rtrn_nxt && !st_vld;
    end
    if (!drained) begin
      report_error($sformatf("buffer still busy after %0d drain cycles", DRAIN_MAX));
    end
    check_bit("empty_at_end", 1'b1, s_empty);
    check_bit("req_idle_at_end", 1'b0, s_req);
    finish_test();

    cur_test = "final_image";
    for (int w = 0; w < NWORDS; w++) begin
      if (written[w] != '0) begin
        check_be($sformatf("bytes word %0d", w), written[w], mem_be[w]);
        check_data($sformatf("data word %0d", w),
                   exp_img[w] & byte_bits(written[w]),
                   mem_img[w] & byte_bits(written[w]));
      end
    end
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // four times the nominal run length
  initial begin : p_watchdog
    #(TEST_CYC * 400);
    $display("Error watchdog: run did not end within %0d cycles", TEST_CYC * 4);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* wbuf/wbuf_store.sv */
// entry array of the write buffer, merges stores and tracks the byte states on send and return

`timescale 1ns/100ps

`include "wbuf_settings.svh"

module wbuf_store
  import wbuf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_valid_i,
  input  wr_req_t                  wr_req_i,
  input  logic                     send_i,
  input  ptr_t                     send_ptr_i,
  input  be_t                      send_be_i,
  input  logic                     evict_i,
  input  ptr_t                     evict_ptr_i,
  input  be_t                      evict_be_i,
  output logic                     wr_gnt_o,
  output entry_t [`WBUF_DEPTH-1:0] entries_o,
  output logic [`WBUF_DEPTH-1:0]   dirty_o,
  output logic                     empty_o
);

  // byte states valid/dirty/txblock
  //   000 free, 110 waiting, 101 in flight, 111 rewritten while in flight
  be_t [`WBUF_DEPTH-1:0] valid_q, valid_d;
  be_t [`WBUF_DEPTH-1:0] dirty_q, dirty_d;
  be_t [`WBUF_DEPTH-1:0] txblock_q, txblock_d;
  waddr_t waddr_q [`WBUF_DEPTH];
  waddr_t waddr_d [`WBUF_DEPTH];
  data_t  data_q [`WBUF_DEPTH];
  data_t  data_d [`WBUF_DEPTH];

  logic [`WBUF_DEPTH-1:0] used;
  logic hit;
  logic full;
  ptr_t hit_ptr;
  ptr_t free_ptr;
  ptr_t wr_ptr;

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign used[k] = |valid_q[k];
    // a word with bytes in flight must wait, transfers may overtake each other
    assign dirty_o[k] = ~(|txblock_q[k]) & (|(dirty_q[k] & valid_q[k]));
    assign entries_o[k] = '{
      waddr:   waddr_q[k],
      data:    data_q[k],
      valid:   valid_q[k],
      dirty:   dirty_q[k],
      txblock: txblock_q[k]
    };
  end

  ////////////////////
  // hit and free search
  ////////////////////

  // walk down so the lowest index wins
  always_comb begin : p_search
    hit      = 1'b0;
    hit_ptr  = '0;
    full     = 1'b1;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (used[k] && (waddr_q[k] == wr_req_i.waddr)) begin
        hit     = 1'b1;
        hit_ptr = ptr_t'(k);
      end
      if (!used[k]) begin
        full     = 1'b0;
        free_ptr = ptr_t'(k);
      end
    end
  end

  assign wr_ptr   = hit ? hit_ptr : free_ptr;
  assign wr_gnt_o = hit | ~full;
  assign empty_o  = ~(|used);

  ////////////////////
  // state update
  ////////////////////

  always_comb begin : p_update
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;
    waddr_d   = waddr_q;
    data_d    = data_q;

    // return clears in-flight bits, clean bytes are freed
    if (evict_i) begin
      txblock_d[evict_ptr_i] = txblock_q[evict_ptr_i] & ~evict_be_i;
      valid_d[evict_ptr_i]   = valid_q[evict_ptr_i] & ~(evict_be_i & ~dirty_q[evict_ptr_i]);
    end

    // sent bytes move from dirty to in flight
    if (send_i) begin
      dirty_d[send_ptr_i]   = dirty_q[send_ptr_i] & ~send_be_i;
      txblock_d[send_ptr_i] = txblock_q[send_ptr_i] | send_be_i;
    end

    // store merge comes last so new bytes stay dirty
    if (wr_valid_i && wr_gnt_o) begin
      waddr_d[wr_ptr] = wr_req_i.waddr;
      valid_d[wr_ptr] = valid_d[wr_ptr] | wr_req_i.be;
      dirty_d[wr_ptr] = dirty_d[wr_ptr] | wr_req_i.be;
      for (int b = 0; b < `WBUF_NBYTES; b++) begin
        if (wr_req_i.be[b]) begin
          data_d[wr_ptr][b*8 +: 8] = wr_req_i.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    waddr_q <= waddr_d;
    data_q  <= data_d;
  end

endmodule

/* wbuf/wbuf_top.sv */
// coalescing write buffer top, takes core stores and issues aligned memory writes with ids

`timescale 1ns/100ps

`include "wbuf_settings.svh"

module wbuf_top
  import wbuf_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // core store port
  input  logic     wr_valid_i,
  input  wr_req_t  wr_req_i,
  output logic     wr_gnt_o,
  // memory write port
  output logic     mem_req_o,
  output mem_req_t mem_req_i_o,
  input  logic     mem_ack_i,
  // write acknowledgements, any order
  input  logic     mem_rtrn_vld_i,
  input  tx_id_t   mem_rtrn_id_i,
  // no valid byte left in the buffer
  output logic     empty_o
);

  entry_t [`WBUF_DEPTH-1:0] entries;
  logic   [`WBUF_DEPTH-1:0] dirty;
  logic   pend;
  logic   free;
  logic   send;
  logic   evict;
  ptr_t   sel_ptr;
  ptr_t   evict_ptr;
  boff_t  sel_off;
  size_t  sel_size;
  be_t    sel_be;
  be_t    evict_be;
  tx_id_t tx_id;

  // request needs a dirty entry and a free id
  assign mem_req_o = pend & free;
  assign send      = mem_req_o & mem_ack_i;

  // whole stored word goes out, size picks the bytes
  assign mem_req_i_o = '{
    waddr: entries[sel_ptr].waddr,
    off:   sel_off,
    size:  sel_size,
    data:  entries[sel_ptr].data,
    id:    tx_id
  };

  wbuf_store i_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_valid_i  (wr_valid_i),
    .wr_req_i    (wr_req_i),
    .send_i      (send),
    .send_ptr_i  (sel_ptr),
    .send_be_i   (sel_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .wr_gnt_o    (wr_gnt_o),
    .entries_o   (entries),
    .dirty_o     (dirty),
    .empty_o     (empty_o)
  );

  wbuf_tx_select i_tx_select (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .entries_i (entries),
    .dirty_i   (dirty),
    .send_i    (send),
    .pend_o    (pend),
    .ptr_o     (sel_ptr),
    .off_o     (sel_off),
    .size_o    (sel_size),
    .be_o      (sel_be)
  );

  wbuf_tx_tracker i_tx_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .send_i      (send),
    .send_ptr_i  (sel_ptr),
    .send_be_i   (sel_be),
    .rtrn_vld_i  (mem_rtrn_vld_i),
    .rtrn_id_i   (mem_rtrn_id_i),
    .free_o      (free),
    .tx_id_o     (tx_id),
    .evict_o     (evict),
    .evict_ptr_o (evict_ptr),
    .evict_be_o  (evict_be)
  );

endmodule

/* wbuf/wbuf_tx_select.sv */
// picks the next dirty entry round-robin and shapes its next aligned transfer

`timescale 1ns/100ps

`include "wbuf_settings.svh"

module wbuf_tx_select
  import wbuf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  logic [`WBUF_DEPTH-1:0]   dirty_i,
  input  logic                     send_i,
  output logic                     pend_o,
  output ptr_t                     ptr_o,
  output boff_t                    off_o,
  output size_t                    size_o,
  output be_t                      be_o
);

  ptr_t rr_q;
  ptr_t pick;
  ptr_t lock_ptr_q;
  logic lock_q;
  be_t  bdirty;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (int'(p) == `WBUF_DEPTH - 1) ? ptr_t'(0) : ptr_t'(int'(p) + 1);
  endfunction

  assign pend_o = |dirty_i;

  ////////////////////
  // round-robin pick
  ////////////////////

  // first dirty entry at or after the rr pointer
  always_comb begin : p_pick
    logic found;
    int   idx;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < `WBUF_DEPTH; i++) begin
      idx = (int'(rr_q) + i) % `WBUF_DEPTH;
      if (!found && dirty_i[idx]) begin
        found = 1'b1;
        pick  = ptr_t'(idx);
      end
    end
  end

  // held while the request waits for its ack
  assign ptr_o  = lock_q ? lock_ptr_q : pick;
  // stores may widen the dirty bytes of a locked entry
  assign bdirty = entries_i[ptr_o].dirty;

  ////////////////////
  // transfer shape
  ////////////////////

  always_comb begin : p_shape
    logic [15:0] span;
    logic        done;
    off_o  = '0;
    size_o = '0;
    be_o   = '0;
    done   = 1'b0;
    // lowest dirty byte
    for (int b = `WBUF_NBYTES - 1; b >= 0; b--) begin
      if (bdirty[b]) begin
        off_o = boff_t'(b);
      end
    end
    // largest aligned run of dirty bytes starting at the offset
    for (int s = 3; s >= 0; s--) begin
      span = ((16'd1 << (1 << s)) - 16'd1) << off_o;
      if (!done && ((int'(off_o) % (1 << s)) == 0) && ((bdirty & be_t'(span)) == be_t'(span))) begin
        done   = 1'b1;
        size_o = size_t'(s);
        be_o   = be_t'(span);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_ptr_q <= '0;
    end else begin
      lock_q     <= pend_o & ~send_i;
      lock_ptr_q <= ptr_o;
      // start after the served entry next time
      if (send_i) begin
        rr_q <= next_ptr(ptr_o);
      end
    end
  end

endmodule

/* wbuf/wbuf_tx_tracker.sv */
// transaction slot table with free id pick and an in-order queue of returned ids

`timescale 1ns/100ps

`include "wbuf_settings.svh"

module wbuf_tx_tracker
  import wbuf_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   send_i,
  input  ptr_t   send_ptr_i,
  input  be_t    send_be_i,
  input  logic   rtrn_vld_i,
  input  tx_id_t rtrn_id_i,
  output logic   free_o,
  output tx_id_t tx_id_o,
  output logic   evict_o,
  output ptr_t   evict_ptr_o,
  output be_t    evict_be_o
);

  tx_stat_t tx_stat_q [`WBUF_MAX_TX];
  tx_stat_t tx_stat_d [`WBUF_MAX_TX];
  logic [`WBUF_MAX_TX-1:0] slot_free;
  tx_id_t id_rr_q;

  // return queue, holds at most one entry per id
  tx_id_t fifo_q [`WBUF_MAX_TX];
  tx_id_t wr_q;
  tx_id_t rd_q;
  logic [$clog2(`WBUF_MAX_TX):0] cnt_q;
  tx_id_t rtrn_id;

  function automatic tx_id_t next_id(input tx_id_t id);
    return (int'(id) == `WBUF_MAX_TX - 1) ? tx_id_t'(0) : tx_id_t'(int'(id) + 1);
  endfunction

  for (genvar i = 0; i < `WBUF_MAX_TX; i++) begin : gen_free
    assign slot_free[i] = ~tx_stat_q[i].vld;
  end

  assign free_o = |slot_free;

  ////////////////////
  // free id pick
  ////////////////////

  always_comb begin : p_id_pick
    logic found;
    int   idx;
    found   = 1'b0;
    tx_id_o = '0;
    for (int i = 0; i < `WBUF_MAX_TX; i++) begin
      idx = (int'(id_rr_q) + i) % `WBUF_MAX_TX;
      if (!found && slot_free[idx]) begin
        found   = 1'b1;
        tx_id_o = tx_id_t'(idx);
      end
    end
  end

  ////////////////////
  // eviction and slot update
  ////////////////////

  // queue head retires one transaction per cycle
  assign evict_o     = (cnt_q != '0);
  assign rtrn_id     = fifo_q[rd_q];
  assign evict_ptr_o = tx_stat_q[rtrn_id].ptr;
  assign evict_be_o  = tx_stat_q[rtrn_id].be;

  always_comb begin : p_slots
    tx_stat_d = tx_stat_q;
    if (evict_o) begin
      tx_stat_d[rtrn_id].vld = 1'b0;
    end
    // the picked id is free, so it never collides with the evicted one
    if (send_i) begin
      tx_stat_d[tx_id_o] = '{vld: 1'b1, be: send_be_i, ptr: send_ptr_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      for (int i = 0; i < `WBUF_MAX_TX; i++) begin
        tx_stat_q[i] <= '0;
      end
      id_rr_q <= '0;
      wr_q    <= '0;
      rd_q    <= '0;
      cnt_q   <= '0;
    end else begin
      tx_stat_q <= tx_stat_d;
      if (send_i) begin
        id_rr_q <= next_id(tx_id_o);
      end
      if (rtrn_vld_i) begin
        wr_q <= next_id(wr_q);
      end
      if (evict_o) begin
        rd_q <= next_id(rd_q);
      end
      // occupancy follows push and pop
      if (rtrn_vld_i && !evict_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!rtrn_vld_i && evict_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (rtrn_vld_i) begin
      fifo_q[wr_q] <= rtrn_id_i;
    end
  end

endmodule
